// ==== test/debug_golden.txt ====
// program: instruction count, then the instruction words in load order
06
00500093 00300113 002081b3
40208233 0041a023 00000063
// record count, then per record: command, pc_i, cycle_count_i, halt delay
06
55 00 00 00 // unknown code
0F 04 01 00 // step
F0 1C 09 05 // continue
A5 00 00 00 // unknown code
F0 30 2A 0C // continue, longer run
0F 34 2B 00 // step

// ==== src.f ====
source/debug_pkg.sv
source/program_loader.sv
source/dump_sender.sv
source/debug_control.sv
source/debug_unit_top.sv
test/tb_clock_gen.sv
test/debug_monitor.sv
test/debug_unit_sva.sv
test/tb_debug_unit.sv

// ==== Bender.yml ====
package:
  name: debug_unit

sources:
  - source/debug_pkg.sv
  - source/program_loader.sv
  - source/dump_sender.sv
  - source/debug_control.sv
  - source/debug_unit_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/debug_monitor.sv
      - test/debug_unit_sva.sv
      - test/tb_debug_unit.sv

// ==== test/tb_debug_unit.sv ====
module tb_debug_unit
	import debug_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int GOLDEN_LEN = 32;
	localparam int DUMP_BYTES = 2 + BYTES_PER_WORD * (N_REGS + N_MEM_WORDS);

	logic        clock;
	logic        reset;
	logic        rx_valid    = 1'b0;
	byte_t       rx_byte     = '0;
	logic        tx_done     = 1'b0;
	logic        halt        = 1'b0;
	byte_t       pc          = '0;
	byte_t       cycle_count = '0;
	word_t       reg_data;
	word_t       mem_data;
	logic        tx_start;
	byte_t       tx_byte;
	logic        imem_we;
	imem_addr_t  imem_addr;
	word_t       imem_data;
	reg_addr_t   reg_addr;
	mem_addr_t   mem_addr;
	logic        pipe_enable;
	logic        loading;
	logic        dump_active;
	logic        ack;
	logic        dump_done;
	word_t       golden [0:GOLDEN_LEN-1];
	int unsigned rand_state  = 94;
	int          done_wait   = 0;
	int          cycle_cnt   = 0;
	int          cycle_limit = 0;
	int          n_words;
	int          n_records;
	int          errs;

	tb_clock_gen u_clock (
		.clock_o (clock),
		.reset_o (reset)
	);

	debug_unit_top u_dut (
		.clock_i       (clock),
		.reset_i       (reset),
		.rx_valid_i    (rx_valid),
		.rx_byte_i     (rx_byte),
		.tx_done_i     (tx_done),
		.tx_start_o    (tx_start),
		.tx_byte_o     (tx_byte),
		.halt_i        (halt),
		.pc_i          (pc),
		.cycle_count_i (cycle_count),
		.reg_data_i    (reg_data),
		.mem_data_i    (mem_data),
		.imem_we_o     (imem_we),
		.imem_addr_o   (imem_addr),
		.imem_data_o   (imem_data),
		.reg_addr_o    (reg_addr),
		.mem_addr_o    (mem_addr),
		.pipe_enable_o (pipe_enable),
		.loading_o     (loading),
		.dump_active_o (dump_active),
		.ack_o         (ack),
		.dump_done_o   (dump_done)
	);

	debug_monitor u_mon (
		.clock_i       (clock),
		.imem_we_i     (imem_we),
		.imem_addr_i   (imem_addr),
		.imem_data_i   (imem_data),
		.tx_start_i    (tx_start),
		.tx_byte_i     (tx_byte),
		.tx_done_i     (tx_done),
		.pipe_enable_i (pipe_enable),
		.loading_i     (loading),
		.dump_active_i (dump_active),
		.ack_i         (ack),
		.dump_done_i   (dump_done)
	);

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic word_t reg_word(input int k);
		return word_t'(k) * 32'h10000001;
	endfunction

	function automatic word_t mem_word(input int m);
		return ~(word_t'(m) * 32'h01010101);
	endfunction

	// register file and data memory, answered in the same cycle
	always_comb
	begin
		reg_data = reg_word(reg_addr);
		mem_data = mem_word(mem_addr);
	end

	// host transmitter, done after 1 to 8 cycles
	always @(posedge clock)
	begin
		tx_done <= 1'b0;
		if (tx_start)
		begin
			rand_state = lcg_next(rand_state);
			done_wait <= 1 + int'((rand_state >> 16) % 8);
		end
		else if (done_wait > 0)
		begin
			done_wait <= done_wait - 1;
			if (done_wait == 1)
				tx_done <= 1'b1;
		end
	end

	always @(posedge clock)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic send_byte(input byte_t b);
		@(posedge clock);
		rx_valid <= 1'b1;
		rx_byte  <= b;
		@(posedge clock);
		rx_valid <= 1'b0;
	endtask

	task automatic settle(input int n);
		repeat (n) @(posedge clock);
		@(negedge clock);
	endtask

	task automatic expect_dump(input byte_t pc_val, input byte_t cyc_val);
		word_t w;
		u_mon.expect_byte(pc_val);
		u_mon.expect_byte(cyc_val);
		for (int k = 0; k < N_REGS; k++)
		begin
			w = reg_word(k);
			for (int b = 0; b < BYTES_PER_WORD; b++)
				u_mon.expect_byte(w[8*b +: 8]); // lsb first
		end
		for (int m = 0; m < N_MEM_WORDS; m++)
		begin
			w = mem_word(m);
			for (int b = 0; b < BYTES_PER_WORD; b++)
				u_mon.expect_byte(w[8*b +: 8]);
		end
	endtask

	task automatic load_program();
		word_t w;
		@(negedge clock);
		u_mon.start_test("program load");
		for (int i = 0; i < n_words; i++)
			u_mon.expect_word(golden[1 + i]);
		send_byte(byte_t'(n_words));
		for (int i = 0; i < n_words; i++)
		begin
			w = golden[1 + i];
			for (int b = 0; b < BYTES_PER_WORD; b++)
				send_byte(w[8*b +: 8]);
		end
		@(posedge clock);
		while (!ack)
			@(posedge clock);
		settle(4);
		u_mon.finish_test(n_words, 0, 0, 1, 0, 1'b0);
	endtask

	task automatic run_command(input int idx);
		int    base;
		int    delay;
		int    exp_pipe;
		byte_t cmd;
		byte_t pc_val;
		byte_t cyc_val;
		string name;
		base    = n_words + 2 + 4 * idx;
		cmd     = golden[base];
		pc_val  = golden[base + 1];
		cyc_val = golden[base + 2];
		delay   = golden[base + 3];
		if (cmd == CMD_STEP)
			name = "step";
		else if (cmd == CMD_CONTINUE)
			name = "continue";
		else
			name = "unknown command";
		@(negedge clock);
		u_mon.start_test(name);
		if (cmd == CMD_STEP || cmd == CMD_CONTINUE)
			expect_dump(pc_val, cyc_val);
		@(posedge clock);
		pc          <= pc_val;
		cycle_count <= cyc_val;
		send_byte(cmd);
		if (cmd == CMD_CONTINUE)
		begin
			@(posedge clock);
			while (!pipe_enable)
				@(posedge clock);
			repeat (delay) @(posedge clock);
			halt <= 1'b1;
			@(posedge clock);
			halt <= 1'b0;
		end
		if (cmd == CMD_STEP || cmd == CMD_CONTINUE)
		begin
			// running holds through the cycle that samples halt
			exp_pipe = (cmd == CMD_STEP) ? 1 : delay + 2;
			@(posedge clock);
			while (!dump_done)
				@(posedge clock);
			settle(4);
			u_mon.finish_test(0, DUMP_BYTES, exp_pipe, 1, 1, 1'b0);
		end
		else
		begin
			settle(20);
			u_mon.finish_test(0, 0, 0, 0, 0, 1'b0);
		end
	endtask

	initial
	begin
		$readmemh("test/debug_golden.txt", golden);
		n_words     = golden[0];
		n_records   = golden[n_words + 1];
		cycle_limit = 30 + (1 + BYTES_PER_WORD * n_words) * 8 + 200;
		for (int r = 0; r < n_records; r++)
			cycle_limit += (DUMP_BYTES + 1) * 10 + golden[n_words + 2 + 4 * r + 3];

		@(negedge clock);
		while (reset)
			@(negedge clock);
		u_mon.start_test("reset");
		settle(8);
		u_mon.finish_test(0, 0, 0, 0, 0, 1'b1);

		load_program();
		for (int r = 0; r < n_records; r++)
			run_command(r);

		settle(2);
		u_mon.report(u_dut.u_sva.fail_count, errs);
		if (errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== test/debug_unit_sva.sv ====
module debug_unit_sva (
	input logic clock_i,
	input logic reset_i,
	input logic tx_start_o,
	input logic tx_done_i,
	input logic imem_we_o,
	input logic loading_o,
	input logic pipe_enable_o,
	input logic dump_active_o
);
	timeunit 1ns;
	timeprecision 1ps;

	int   fail_count = 0;
	logic byte_in_flight; // started, done not seen yet

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			byte_in_flight <= 1'b0;
		else if (tx_start_o)
			byte_in_flight <= 1'b1;
		else if (tx_done_i)
			byte_in_flight <= 1'b0;
	end

	tx_one_in_flight: assert property (@(posedge clock_i) disable iff (reset_i)
		tx_start_o |-> !byte_in_flight)
	else
	begin
		fail_count++;
		$error("tx_start_o repeated before tx_done_i");
	end

	we_while_loading: assert property (@(posedge clock_i) disable iff (reset_i)
		imem_we_o |-> loading_o)
	else
	begin
		fail_count++;
		$error("imem_we_o outside the program load");
	end

	no_run_in_dump: assert property (@(posedge clock_i) disable iff (reset_i)
		!(pipe_enable_o && dump_active_o))
	else
	begin
		fail_count++;
		$error("pipe_enable_o high during the dump");
	end

endmodule

bind debug_unit_top debug_unit_sva u_sva (
	.clock_i       (clock_i),
	.reset_i       (reset_i),
	.tx_start_o    (tx_start_o),
	.tx_done_i     (tx_done_i),
	.imem_we_o     (imem_we_o),
	.loading_o     (loading_o),
	.pipe_enable_o (pipe_enable_o),
	.dump_active_o (dump_active_o)
);

// ==== test/debug_monitor.sv ====
module debug_monitor
	import debug_pkg::*;
(
	input logic       clock_i,
	input logic       imem_we_i,
	input imem_addr_t imem_addr_i,
	input word_t      imem_data_i,
	input logic       tx_start_i,
	input byte_t      tx_byte_i,
	input logic       tx_done_i,
	input logic       pipe_enable_i,
	input logic       loading_i,
	input logic       dump_active_i,
	input logic       ack_i,
	input logic       dump_done_i
);
	timeunit 1ns;
	timeprecision 1ps;

	word_t exp_words[$];
	byte_t exp_bytes[$];
	string test_name;
	logic  in_test = 1'b0;
	int    cyc = 0;
	int    test_num = 0;
	int    passed = 0;
	int    total_errors = 0;
	int    test_errors;
	int    n_we, n_tx, n_pipe, n_ack, n_done;
	int    n_active; // cycles with the read ports handed to the dump
	int    last_we, last_pipe, last_done; // cycle stamps of the latest events
	int    write_idx;

	task automatic mismatch(input string sig, input word_t exp, input word_t act);
		$display("[ERROR] %s: expected 0x%0h, got 0x%0h", sig, exp, act);
		test_errors++;
	endtask

	task automatic problem(input string what);
		$display("%s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_num++;
		test_errors = 0;
		n_we        = 0;
		n_tx        = 0;
		n_pipe      = 0;
		n_ack       = 0;
		n_done      = 0;
		n_active    = 0;
		last_we     = -100;
		last_pipe   = -100;
		last_done   = -100;
		write_idx   = 0;
		exp_words.delete();
		exp_bytes.delete();
		in_test = 1'b1;
	endtask

	task automatic expect_word(input word_t w);
		exp_words.push_back(w);
	endtask

	task automatic expect_byte(input byte_t b);
		exp_bytes.push_back(b);
	endtask

	task automatic check_write();
		word_t w;
		n_we++;
		last_we = cyc;
		if (exp_words.size() == 0)
			problem("instruction memory write with no word left to load");
		else
		begin
			w = exp_words.pop_front();
			if (imem_addr_i !== imem_addr_t'(write_idx))
				mismatch("imem_addr_o", write_idx, imem_addr_i);
			if (imem_data_i !== w)
				mismatch("imem_data_o", w, imem_data_i);
		end
		write_idx++;
	endtask

	task automatic check_tx();
		byte_t b;
		// dump starts two cycles after the last pipeline cycle
		if (n_tx == 0 && cyc - last_pipe != 2)
			problem("first tx_start_o not two cycles after pipe_enable_o");
		else if (n_tx > 0 && cyc - last_done != 1)
			problem("tx_start_o did not follow tx_done_i by one cycle");
		if (dump_active_i !== 1'b1)
			problem("tx_start_o while dump_active_o was low");
		n_tx++;
		if (exp_bytes.size() == 0)
			problem("byte sent past the end of the dump");
		else
		begin
			b = exp_bytes.pop_front();
			if (tx_byte_i !== b)
				mismatch("tx_byte_o", b, tx_byte_i);
		end
	endtask

	always @(posedge clock_i)
	begin
		cyc++;
		if (in_test)
		begin
			if (imem_we_i)
				check_write();
			if (pipe_enable_i)
			begin
				n_pipe++;
				last_pipe = cyc;
			end
			if (dump_active_i)
				n_active++;
			if (tx_start_i)
				check_tx();
			if (tx_done_i)
				last_done = cyc;
			if (ack_i)
			begin
				n_ack++;
				if (n_we > 0 && cyc - last_we != 1)
					problem("ack_o did not follow the last write by one cycle");
			end
			if (dump_done_i)
			begin
				n_done++;
				if (!ack_i)
					problem("dump_done_o came without ack_o");
				if (cyc - last_done != 1)
					problem("dump_done_o not one cycle after the last tx_done_i");
			end
		end
	end

	task automatic finish_test(input int exp_we, input int exp_tx, input int exp_pipe,
		input int exp_ack, input int exp_done, input logic exp_loading);
		in_test = 1'b0;
		if (n_we != exp_we)
			mismatch("imem_we_o pulses", exp_we, n_we);
		if (n_tx != exp_tx)
			mismatch("tx_start_o pulses", exp_tx, n_tx);
		if (n_pipe != exp_pipe)
			mismatch("pipe_enable_o cycles", exp_pipe, n_pipe);
		if (n_ack != exp_ack)
			mismatch("ack_o pulses", exp_ack, n_ack);
		if (n_done != exp_done)
			mismatch("dump_done_o pulses", exp_done, n_done);
		if (exp_done == 0 && n_active != 0)
			mismatch("dump_active_o cycles", 0, n_active);
		if (loading_i !== exp_loading)
			mismatch("loading_o", exp_loading, loading_i);
		if (dump_active_i !== 1'b0)
			mismatch("dump_active_o", 0, dump_active_i);
		if (test_errors == 0)
		begin
			passed++;
			$display("test %0d %s: ok", test_num, test_name);
		end
		else
			$display("test %0d %s: %0d errors", test_num, test_name, test_errors);
		total_errors += test_errors;
	endtask

	task automatic report(input int assert_fails, output int errors);
		$display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
			test_num, passed, test_num - passed, total_errors, assert_fails);
		errors = total_errors + assert_fails;
	endtask

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clock_o,
	output logic reset_o
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clock_o = 1'b0;
		forever #2 clock_o = ~clock_o; // 4 ns period
	end

	initial
	begin
		reset_o = 1'b1;
		repeat (10) @(posedge clock_o);
		reset_o <= 1'b0;
	end

endmodule

// ==== source/debug_unit_top.sv ====
module debug_unit_top
	import debug_pkg::*;
(
	input  logic       clock_i,
	input  logic       reset_i,
	input  logic       rx_valid_i,
	input  byte_t      rx_byte_i,
	input  logic       tx_done_i,
	output logic       tx_start_o,
	output byte_t      tx_byte_o,
	input  logic       halt_i,
	input  byte_t      pc_i,
	input  byte_t      cycle_count_i,
	input  word_t      reg_data_i,
	input  word_t      mem_data_i,
	output logic       imem_we_o,
	output imem_addr_t imem_addr_o,
	output word_t      imem_data_o,
	output reg_addr_t  reg_addr_o,
	output mem_addr_t  mem_addr_o,
	output logic       pipe_enable_o,
	output logic       loading_o,
	output logic       dump_active_o,
	output logic       ack_o,
	output logic       dump_done_o
);

	logic load_count_en;
	logic load_words_en;
	logic count_taken;   // count byte accepted
	logic load_finished; // last instruction written
	logic dump_start;
	logic dump_finished;

	debug_control u_control (
		.clock_i         (clock_i),
		.reset_i         (reset_i),
		.rx_valid_i      (rx_valid_i),
		.rx_byte_i       (rx_byte_i),
		.halt_i          (halt_i),
		.count_taken_i   (count_taken),
		.load_finished_i (load_finished),
		.dump_finished_i (dump_finished),
		.load_count_en_o (load_count_en),
		.load_words_en_o (load_words_en),
		.dump_start_o    (dump_start),
		.pipe_enable_o   (pipe_enable_o),
		.loading_o       (loading_o),
		.dump_active_o   (dump_active_o),
		.ack_o           (ack_o),
		.dump_done_o     (dump_done_o)
	);

	program_loader u_loader (
		.clock_i         (clock_i),
		.reset_i         (reset_i),
		.load_count_en_i (load_count_en),
		.load_words_en_i (load_words_en),
		.rx_valid_i      (rx_valid_i),
		.rx_byte_i       (rx_byte_i),
		.count_taken_o   (count_taken),
		.load_finished_o (load_finished),
		.imem_we_o       (imem_we_o),
		.imem_addr_o     (imem_addr_o),
		.imem_data_o     (imem_data_o)
	);

	dump_sender u_sender (
		.clock_i         (clock_i),
		.reset_i         (reset_i),
		.dump_start_i    (dump_start),
		.tx_done_i       (tx_done_i),
		.pc_i            (pc_i),
		.cycle_count_i   (cycle_count_i),
		.reg_data_i      (reg_data_i),
		.mem_data_i      (mem_data_i),
		.tx_start_o      (tx_start_o),
		.tx_byte_o       (tx_byte_o),
		.reg_addr_o      (reg_addr_o),
		.mem_addr_o      (mem_addr_o),
		.dump_finished_o (dump_finished)
	);

endmodule

// ==== source/debug_control.sv ====
module debug_control
	import debug_pkg::*;
(
	input  logic  clock_i,
	input  logic  reset_i,
	input  logic  rx_valid_i,
	input  byte_t rx_byte_i,
	input  logic  halt_i,
	input  logic  count_taken_i,
	input  logic  load_finished_i,
	input  logic  dump_finished_i,
	output logic  load_count_en_o,
	output logic  load_words_en_o,
	output logic  dump_start_o,
	output logic  pipe_enable_o,
	output logic  loading_o,
	output logic  dump_active_o,
	output logic  ack_o,
	output logic  dump_done_o
);

	debug_state_t state_q;
	debug_state_t state_next;
	byte_t        cmd_q; // last command byte from the host

	assign load_count_en_o = (state_q == LOAD_COUNT);
	assign load_words_en_o = (state_q == LOAD_WORDS);
	assign loading_o       = load_count_en_o | load_words_en_o;
	assign dump_active_o   = (state_q == DUMP); // outside hands the read ports over

	always_comb
	begin
		state_next = state_q;
		case (state_q)
			LOAD_COUNT:
				if (count_taken_i)
					state_next = LOAD_WORDS;
			LOAD_WORDS:
				if (load_finished_i)
					state_next = WAIT_CMD;
			WAIT_CMD:
				if (rx_valid_i)
					state_next = CHECK_CMD;
			CHECK_CMD:
			begin
				case (cmd_q)
					CMD_STEP:     state_next = STEP;
					CMD_CONTINUE: state_next = RUN;
					default:      state_next = WAIT_CMD; // unknown codes are dropped
				endcase
			end
			STEP:
				state_next = DUMP;
			RUN:
				// halt only matters while running freely
				if (halt_i)
					state_next = DUMP;
			DUMP:
				if (dump_finished_i)
					state_next = WAIT_CMD;
			default:
				state_next = LOAD_COUNT;
		endcase
	end

	always_ff @(posedge clock_i)
	begin
		if (state_q == WAIT_CMD && rx_valid_i)
			cmd_q <= rx_byte_i;
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			state_q       <= LOAD_COUNT;
			pipe_enable_o <= 1'b0;
			dump_start_o  <= 1'b0;
			ack_o         <= 1'b0;
			dump_done_o   <= 1'b0;
		end
		else
		begin
			state_q <= state_next;
			// high for the whole STEP or RUN state
			pipe_enable_o <= (state_next == STEP) || (state_next == RUN);
			dump_start_o  <= (state_next == DUMP) && (state_q != DUMP);
			dump_done_o   <= dump_active_o && dump_finished_i;
			// host may talk again after a load or a dump
			ack_o <= (load_words_en_o && load_finished_i) ||
				(dump_active_o && dump_finished_i);
		end
	end

endmodule

// ==== source/dump_sender.sv ====
module dump_sender
	import debug_pkg::*;
(
	input  logic      clock_i,
	input  logic      reset_i,
	input  logic      dump_start_i,
	input  logic      tx_done_i,
	input  byte_t     pc_i,
	input  byte_t     cycle_count_i,
	input  word_t     reg_data_i,
	input  word_t     mem_data_i,
	output logic      tx_start_o,
	output byte_t     tx_byte_o,
	output reg_addr_t reg_addr_o,
	output mem_addr_t mem_addr_o,
	output logic      dump_finished_o
);

	// position registers always point at the next byte to go out,
	// so the read ports settle while the previous byte is in flight
	dump_sel_t  sel_q;
	logic [1:0] byte_idx_q;
	logic       busy_q;
	logic       last_q;   // final memory byte already issued
	logic       send;
	logic       word_end;
	byte_t      cur_byte;

	assign word_end        = (byte_idx_q == 2'(BYTES_PER_WORD - 1));
	assign send            = dump_start_i | (busy_q & tx_done_i & ~last_q);
	assign dump_finished_o = busy_q & tx_done_i & last_q;

	always_comb
	begin
		case (sel_q)
			DUMP_PC:     cur_byte = pc_i;
			DUMP_CYCLES: cur_byte = cycle_count_i;
			DUMP_REGS:   cur_byte = reg_data_i[8*byte_idx_q +: 8];
			default:     cur_byte = mem_data_i[8*byte_idx_q +: 8];
		endcase
	end

	always_ff @(posedge clock_i)
	begin
		if (send)
			tx_byte_o <= cur_byte;
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			tx_start_o <= 1'b0;
			busy_q     <= 1'b0;
			last_q     <= 1'b0;
			sel_q      <= DUMP_PC;
			byte_idx_q <= '0;
			reg_addr_o <= '0;
			mem_addr_o <= '0;
		end
		else
		begin
			tx_start_o <= send;
			if (dump_start_i)
				busy_q <= 1'b1;
			else if (dump_finished_o)
			begin
				busy_q <= 1'b0;
				last_q <= 1'b0;
			end
			if (send)
			begin
				case (sel_q)
					DUMP_PC:
						sel_q <= DUMP_CYCLES;
					DUMP_CYCLES:
						sel_q <= DUMP_REGS;
					DUMP_REGS:
					begin
						byte_idx_q <= byte_idx_q + 2'd1;
						if (word_end)
						begin
							reg_addr_o <= reg_addr_o + 5'd1; // wraps to 0 after the last register
							if (reg_addr_o == reg_addr_t'(N_REGS - 1))
								sel_q <= DUMP_MEM;
						end
					end
					default:
					begin
						byte_idx_q <= byte_idx_q + 2'd1;
						if (word_end)
						begin
							mem_addr_o <= mem_addr_o + 4'd1;
							// back at the pc section, ready for the next dump
							if (mem_addr_o == mem_addr_t'(N_MEM_WORDS - 1))
							begin
								sel_q  <= DUMP_PC;
								last_q <= 1'b1;
							end
						end
					end
				endcase
			end
		end
	end

endmodule

// ==== source/program_loader.sv ====
module program_loader
	import debug_pkg::*;
(
	input  logic       clock_i,
	input  logic       reset_i,
	input  logic       load_count_en_i,
	input  logic       load_words_en_i,
	input  logic       rx_valid_i,
	input  byte_t      rx_byte_i,
	output logic       count_taken_o,
	output logic       load_finished_o,
	output logic       imem_we_o,
	output imem_addr_t imem_addr_o,
	output word_t      imem_data_o
);

	byte_t      count_q; // number of instructions announced by the host
	logic [1:0] byte_cnt;
	logic       take_byte;
	logic       word_done;

	assign count_taken_o = load_count_en_i & rx_valid_i;
	assign take_byte     = load_words_en_i & rx_valid_i;
	assign word_done     = take_byte && (byte_cnt == 2'(BYTES_PER_WORD - 1));

	always_ff @(posedge clock_i)
	begin
		if (count_taken_o)
			count_q <= rx_byte_i;
		// new byte enters at the top, first byte ends up lowest
		if (take_byte)
			imem_data_o <= {rx_byte_i, imem_data_o[31:8]};
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			byte_cnt        <= '0;
			imem_addr_o     <= '0;
			imem_we_o       <= 1'b0;
			load_finished_o <= 1'b0;
		end
		else
		begin
			imem_we_o       <= word_done; // one cycle after the fourth byte
			load_finished_o <= word_done && (imem_addr_o == imem_addr_t'(count_q - 8'd1));
			if (take_byte)
				byte_cnt <= byte_cnt + 2'd1; // wraps every word
			if (imem_we_o)
				imem_addr_o <= imem_addr_o + 8'd1;
		end
	end

endmodule

// ==== source/debug_pkg.sv ====
package debug_pkg;

	// widths seen on the host channel and the processor side
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0]  imem_addr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  mem_addr_t;

	localparam int BYTES_PER_WORD = 4; // lsb first on the wire
	localparam int N_REGS         = 32;
	localparam int N_MEM_WORDS    = 16;

	// host commands
	localparam byte_t CMD_STEP     = 8'h0F;
	localparam byte_t CMD_CONTINUE = 8'hF0;

	// dump order: pc, cycles, registers, data memory
	typedef enum logic [1:0] {
		DUMP_PC,
		DUMP_CYCLES,
		DUMP_REGS,
		DUMP_MEM
	} dump_sel_t;

	typedef enum logic [2:0] {
		LOAD_COUNT,
		LOAD_WORDS,
		WAIT_CMD,
		CHECK_CMD,
		STEP,
		RUN,
		DUMP
	} debug_state_t;

endpackage
